/* band_output_stage.sv */
`default_nettype none

module band_output_stage (
	input  logic                               clk,
	input  logic                               arst_n,
	input  fir_bank_pkg::band_frame_t          results,
	input  fir_bank_pkg::band_code_t           result_code,
	input  logic                               result_valid,
	output logic [fir_bank_pkg::acc_width-1:0] dout,
	output logic                               output_data_ready,
	output fir_bank_pkg::band_frame_t          frame
);

	logic [fir_bank_pkg::acc_width-1:0] all_sum;
	logic [fir_bank_pkg::acc_width-1:0] pick;

	// sum of every band, wraps modulo 2^28 through the width
	always_comb
	begin
		all_sum = '0;
		for (int i = 0; i < fir_bank_pkg::num_bands; i++)
		begin
			all_sum = all_sum + results.band[i];
		end
	end

	// codes 0 to 6 select one band
	// anything else is the all-band sum
	always_comb
	begin
		pick = all_sum;
		for (int i = 0; i < fir_bank_pkg::num_bands; i++)
		begin
			if (result_code == fir_bank_pkg::band_code_t'(i))
			begin
				pick = results.band[i];
			end
		end
	end

	// no back-pressure, a valid result always goes out the next cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dout              <= '0;
			frame             <= '0;
			output_data_ready <= 1'b0;
		end
		else
		begin
			output_data_ready <= result_valid;
			if (result_valid)
			begin
				dout  <= pick;
				frame <= results;
			end
		end
	end

endmodule

`default_nettype wire

/* fir_band_mac.sv */
`default_nettype none

module fir_band_mac #(
	parameter int band = 0
) (
	input  logic                               clk,
	input  logic                               arst_n,
	input  fir_bank_pkg::tap_window_t          window,
	input  logic                               window_strobe,
	output logic [fir_bank_pkg::acc_width-1:0] result,
	output fir_bank_pkg::band_code_t           result_code,
	output logic                               result_valid
);

	logic [fir_bank_pkg::num_taps-1:0][fir_bank_pkg::prod_width-1:0] prod;
	logic [fir_bank_pkg::acc_width-1:0]                              sum;

	// one product per tap, coefficients from this band's row
	always_comb
	begin
		for (int i = 0; i < fir_bank_pkg::num_taps; i++)
		begin
			prod[i] = fir_bank_pkg::prod_width'(window.taps[i]) *
				fir_bank_pkg::prod_width'(fir_bank_pkg::band_coefs[band][i]);
		end
	end

	// unsigned sum, fits in 28 bits even at full scale
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < fir_bank_pkg::num_taps; i++)
		begin
			sum = sum + fir_bank_pkg::acc_width'(prod[i]);
		end
	end

	// one-cycle valid pulse per strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= window_strobe;
		end
	end

	// result and its band code held until the next strobe
	always_ff @(posedge clk)
	begin
		if (window_strobe)
		begin
			result      <= sum;
			result_code <= window.code;
		end
	end

endmodule

`default_nettype wire

/* fir_bank.f */
fir_bank_pkg.sv
tap_delay_line.sv
fir_band_mac.sv
band_output_stage.sv
fir_bank_top.sv
tb_clock_gen.sv
fir_bank_properties.sv
fir_bank_tb.sv

/* fir_bank_pkg.sv */
`default_nettype none

package fir_bank_pkg;

	// sample, coefficient and result widths
	localparam int sample_width = 16;
	localparam int coef_width = 8;
	localparam int acc_width = 28;

	// one tap product before accumulation
	localparam int prod_width = sample_width + coef_width;

	// filter geometry
	localparam int num_taps = 7;
	localparam int num_bands = 7;

	// stored samples, the newest tap comes straight from din
	localparam int hist_depth = num_taps - 1;

	localparam int code_width = 3;

	// 0 to 6 pick a coefficient row
	typedef logic [code_width-1:0] band_code_t;

	// code 7 asks for the sum of every band
	localparam band_code_t band_code_sum = 3'd7;

	// one row per band, tap 0 is applied to the newest sample
	// all sets are symmetric so tap order only matters for the impulse response
	localparam logic [coef_width-1:0] band_coefs [num_bands][num_taps] = '{
		// set b
		'{
			8'd29, 8'd101, 8'd15, 8'd235,
			8'd15, 8'd101, 8'd29
		},
		// set c
		'{
			8'd4, 8'd42, 8'd163, 8'd255,
			8'd163, 8'd42, 8'd4
		},
		// set d, centre tap zero
		'{
			8'd12, 8'd77, 8'd148, 8'd0,
			8'd148, 8'd77, 8'd12
		},
		// set 1, centre tap zero
		'{
			8'd15, 8'd25, 8'd193, 8'd0,
			8'd193, 8'd25, 8'd15
		},
		// set 2, same values as set c
		'{
			8'd4, 8'd42, 8'd163, 8'd255,
			8'd163, 8'd42, 8'd4
		},
		// set 3
		'{
			8'd9, 8'd56, 8'd109, 8'd0,
			8'd109, 8'd56, 8'd9
		},
		// set 4, same values as set 3
		'{
			8'd9, 8'd56, 8'd109, 8'd0,
			8'd109, 8'd56, 8'd9
		}
	};

	// tap window seen by every band filter
	// taps[0] is the current sample, taps[num_taps-1] the oldest
	typedef struct packed {
		logic [num_taps-1:0][sample_width-1:0] taps;
		band_code_t                            code;
	} tap_window_t;

	// all band results side by side, band[0] is set b
	typedef struct packed {
		logic [num_bands-1:0][acc_width-1:0] band;
	} band_frame_t;

endpackage

`default_nettype wire

/* fir_bank_properties.sv */
`default_nettype none

module fir_bank_properties (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               new_data_rdy,
	input  logic                               output_data_ready,
	input  logic [fir_bank_pkg::acc_width-1:0] dout
);

	// every strobe comes out two edges later
	property strobe_to_pulse;
		@(posedge clk) disable iff (!arst_n)
			new_data_rdy |-> ##2 output_data_ready;
	endproperty

	// no pulse without a strobe two edges back
	property pulse_has_strobe;
		@(posedge clk) disable iff (!arst_n)
			output_data_ready |-> $past(new_data_rdy, 2);
	endproperty

	property quiet_in_reset;
		@(posedge clk) !arst_n |-> !output_data_ready && (dout == '0);
	endproperty

	a_strobe_to_pulse: assert property (strobe_to_pulse)
		else $error("output_data_ready missing two cycles after a strobe");

	a_pulse_has_strobe: assert property (pulse_has_strobe)
		else $error("output_data_ready without a strobe two cycles earlier");

	a_quiet_in_reset: assert property (quiet_in_reset)
		else $error("output active while arst_n is low");

endmodule

bind fir_bank_top fir_bank_properties u_props (
	.clk              (clk),
	.arst_n           (arst_n),
	.new_data_rdy     (new_data_rdy),
	.output_data_ready(output_data_ready),
	.dout             (dout)
);

`default_nettype wire

/* fir_bank_tb.sv */
`default_nettype none

module fir_bank_tb;

	localparam int drain_limit = 50;
	localparam int reset_limit = 100;

	logic                                  clk;
	logic                                  arst_n;
	logic                                  new_data_rdy;
	logic [fir_bank_pkg::sample_width-1:0] din;
	fir_bank_pkg::band_code_t              band_sel;
	logic [fir_bank_pkg::acc_width-1:0]    dout;
	logic                                  output_data_ready;
	fir_bank_pkg::band_frame_t             frame;

	integer seed;
	string  test_name;
	int     test_errors;
	int     test_checks;
	int     tests_passed;
	int     tests_failed;
	int     total_errors;
	int     pulse_count;
	int     cycle;

	// model history, index 0 is one strobe back
	logic [fir_bank_pkg::sample_width-1:0] model_hist [fir_bank_pkg::hist_depth];
	logic [fir_bank_pkg::acc_width-1:0]    exp_dout_q [$];
	fir_bank_pkg::band_frame_t             exp_frame_q [$];
	int                                    exp_cycle_q [$];

	tb_clock_gen #(
		.period      (40),
		.reset_cycles(10)
	) u_clk (
		.clk   (clk),
		.arst_n(arst_n)
	);

	fir_bank_top dut (
		.clk              (clk),
		.arst_n           (arst_n),
		.new_data_rdy     (new_data_rdy),
		.din              (din),
		.band_sel         (band_sel),
		.dout             (dout),
		.output_data_ready(output_data_ready),
		.frame            (frame)
	);

	// weighted sums of the current sample and the model history
	function automatic fir_bank_pkg::band_frame_t model_frame(
		input logic [fir_bank_pkg::sample_width-1:0] sample
	);
		fir_bank_pkg::band_frame_t             f;
		logic [fir_bank_pkg::sample_width-1:0] taps [fir_bank_pkg::num_taps];
		logic [fir_bank_pkg::acc_width-1:0]    acc;
		taps[0] = sample;
		for (int t = 1; t < fir_bank_pkg::num_taps; t++)
		begin
			taps[t] = model_hist[t-1];
		end
		for (int b = 0; b < fir_bank_pkg::num_bands; b++)
		begin
			acc = '0;
			for (int t = 0; t < fir_bank_pkg::num_taps; t++)
			begin
				acc = acc + fir_bank_pkg::acc_width'(taps[t]) *
					fir_bank_pkg::acc_width'(fir_bank_pkg::band_coefs[b][t]);
			end
			f.band[b] = acc;
		end
		return f;
	endfunction

	// one band, or every band added with wrap
	function automatic logic [fir_bank_pkg::acc_width-1:0] model_select(
		input fir_bank_pkg::band_frame_t f,
		input fir_bank_pkg::band_code_t  code
	);
		logic [fir_bank_pkg::acc_width-1:0] s;
		s = '0;
		if (code == fir_bank_pkg::band_code_sum)
		begin
			for (int b = 0; b < fir_bank_pkg::num_bands; b++)
			begin
				s = s + f.band[b];
			end
		end
		else
		begin
			s = f.band[code];
		end
		return s;
	endfunction

	task automatic record_strobe;
		fir_bank_pkg::band_frame_t f;
		f = model_frame(din);
		exp_frame_q.push_back(f);
		exp_dout_q.push_back(model_select(f, band_sel));
		exp_cycle_q.push_back(cycle);
		for (int i = fir_bank_pkg::hist_depth - 1; i > 0; i--)
		begin
			model_hist[i] = model_hist[i-1];
		end
		model_hist[0] = din;
	endtask

	task automatic check_pulse;
		logic [fir_bank_pkg::acc_width-1:0] exp_dout;
		fir_bank_pkg::band_frame_t          exp_frame;
		int                                 exp_cycle;
		pulse_count++;
		if (exp_dout_q.size() == 0)
		begin
			$display("%s: output_data_ready pulsed with no sample in flight", test_name);
			test_errors++;
		end
		else
		begin
			exp_dout = exp_dout_q.pop_front();
			exp_frame = exp_frame_q.pop_front();
			exp_cycle = exp_cycle_q.pop_front() + 2;
			test_checks++;
			if (cycle != exp_cycle)
			begin
				$display("mismatch %s pulse cycle expected %0d actual %0d",
					test_name, exp_cycle, cycle);
				test_errors++;
			end
			if (dout !== exp_dout)
			begin
				$display("mismatch %s dout expected %h actual %h", test_name, exp_dout, dout);
				test_errors++;
			end
			if (frame !== exp_frame)
			begin
				$display("mismatch %s frame expected %h actual %h", test_name, exp_frame, frame);
				test_errors++;
			end
		end
	endtask

	// inputs and outputs both read before this edge updates them
	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (arst_n)
		begin
			if (output_data_ready)
			begin
				check_pulse();
			end
			if (new_data_rdy)
			begin
				record_strobe();
			end
		end
	end

	task automatic strobe(
		input logic [fir_bank_pkg::sample_width-1:0] sample,
		input fir_bank_pkg::band_code_t              code
	);
		@(posedge clk);
		new_data_rdy <= 1'b1;
		din <= sample;
		band_sel <= code;
	endtask

	// idle cycles carry junk on din and band_sel
	task automatic idle(input int n);
		logic [31:0] r;
		repeat (n)
		begin
			@(posedge clk);
			r = $random(seed);
			new_data_rdy <= 1'b0;
			din <= r[15:0];
			band_sel <= r[18:16];
		end
	endtask

	task automatic wait_reset;
		int n;
		n = 0;
		while (!arst_n && n < reset_limit)
		begin
			@(posedge clk);
			n++;
		end
		if (!arst_n)
		begin
			$display("reset was never released");
			total_errors++;
		end
	endtask

	task automatic new_test(input string name);
		test_name = name;
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic drain_outputs;
		int n;
		idle(2);
		n = 0;
		while (exp_dout_q.size() != 0 && n < drain_limit)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_dout_q.size() != 0)
		begin
			$display("%s: timed out waiting for output_data_ready", test_name);
			test_errors++;
		end
		// catch any extra pulse inside this test
		idle(3);
	endtask

	task automatic report_test;
		if (test_errors == 0)
		begin
			$display("%s: passed, %0d checks", test_name, test_checks);
			tests_passed++;
		end
		else
		begin
			$display("%s: failed, %0d errors in %0d checks", test_name, test_errors, test_checks);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	task automatic reset_state;
		new_test("reset_state");
		repeat (20)
		begin
			@(posedge clk);
			test_checks++;
			if (output_data_ready !== 1'b0)
			begin
				$display("mismatch %s output_data_ready expected 0 actual %b",
					test_name, output_data_ready);
				test_errors++;
			end
			if (dout !== '0)
			begin
				$display("mismatch %s dout expected 0 actual %h", test_name, dout);
				test_errors++;
			end
		end
		report_test();
	endtask

	// each band sees a lone 1 walk through its taps
	task automatic impulse_response;
		new_test("impulse_response");
		repeat (fir_bank_pkg::hist_depth) strobe('0, '0);
		for (int b = 0; b < fir_bank_pkg::num_bands; b++)
		begin
			strobe(16'd1, fir_bank_pkg::band_code_t'(b));
			repeat (fir_bank_pkg::hist_depth) strobe('0, fir_bank_pkg::band_code_t'(b));
		end
		drain_outputs();
		report_test();
	endtask

	task automatic random_bands;
		logic [31:0] r;
		new_test("random_bands");
		repeat (300)
		begin
			r = $random(seed);
			strobe(r[15:0], fir_bank_pkg::band_code_t'(r[23:16] % 8'd7));
			idle(int'(r[29:28]));
		end
		drain_outputs();
		report_test();
	endtask

	task automatic all_band_sum;
		logic [31:0] r;
		new_test("all_band_sum");
		repeat (60)
		begin
			r = $random(seed);
			strobe(r[15:0], fir_bank_pkg::band_code_sum);
			idle(int'(r[29:28]));
		end
		drain_outputs();
		report_test();
	endtask

	task automatic back_to_back;
		logic [31:0] r;
		int          first;
		new_test("back_to_back");
		first = pulse_count;
		repeat (50)
		begin
			r = $random(seed);
			strobe(16'hffff, r[2:0]);
		end
		drain_outputs();
		test_checks++;
		if (pulse_count - first != 50)
		begin
			$display("mismatch %s pulse count expected 50 actual %0d",
				test_name, pulse_count - first);
			test_errors++;
		end
		report_test();
	endtask

	task automatic hold_between_strobes;
		logic [31:0] r;
		new_test("hold_between_strobes");
		repeat (40)
		begin
			r = $random(seed);
			strobe(r[15:0], r[18:16]);
			idle(int'(r[29:28]) + 1);
		end
		drain_outputs();
		report_test();
	endtask

	initial
	begin
		seed = 32'h5ff8;
		new_data_rdy = 1'b0;
		din = '0;
		band_sel = '0;
		test_name = "startup";
		test_errors = 0;
		test_checks = 0;
		tests_passed = 0;
		tests_failed = 0;
		total_errors = 0;
		pulse_count = 0;
		cycle = 0;
		for (int i = 0; i < fir_bank_pkg::hist_depth; i++)
		begin
			model_hist[i] = '0;
		end
		wait_reset();
		reset_state();
		impulse_response();
		random_bands();
		all_band_sum();
		back_to_back();
		hold_between_strobes();
		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0 && total_errors == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* fir_bank_top.sv */
`default_nettype none

module fir_bank_top (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  new_data_rdy,
	input  logic [fir_bank_pkg::sample_width-1:0] din,
	input  fir_bank_pkg::band_code_t              band_sel,
	output logic [fir_bank_pkg::acc_width-1:0]    dout,
	output logic                                  output_data_ready,
	output fir_bank_pkg::band_frame_t             frame
);

	fir_bank_pkg::tap_window_t  window;
	logic                       window_strobe;
	fir_bank_pkg::band_frame_t  results;
	fir_bank_pkg::band_code_t   result_code;
	logic                       result_valid;

	// single history shared by all bands
	tap_delay_line u_delay (
		.clk          (clk),
		.arst_n       (arst_n),
		.new_data_rdy (new_data_rdy),
		.din          (din),
		.band_sel     (band_sel),
		.window       (window),
		.window_strobe(window_strobe)
	);

	// every band registers on the same strobe, so band 0's code and valid
	// stand for the whole set
	for (genvar g = 0; g < fir_bank_pkg::num_bands; g++)
	begin : g_band
		if (g == 0)
		begin : g_lead
			fir_band_mac #(
				.band(g)
			) u_mac (
				.clk          (clk),
				.arst_n       (arst_n),
				.window       (window),
				.window_strobe(window_strobe),
				.result       (results.band[g]),
				.result_code  (result_code),
				.result_valid (result_valid)
			);
		end
		else
		begin : g_rest
			fir_band_mac #(
				.band(g)
			) u_mac (
				.clk          (clk),
				.arst_n       (arst_n),
				.window       (window),
				.window_strobe(window_strobe),
				.result       (results.band[g]),
				.result_code  (),
				.result_valid ()
			);
		end
	end

	band_output_stage u_out (
		.clk              (clk),
		.arst_n           (arst_n),
		.results          (results),
		.result_code      (result_code),
		.result_valid     (result_valid),
		.dout             (dout),
		.output_data_ready(output_data_ready),
		.frame            (frame)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the FIR bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module fir_bank_tb \
	-f fir_bank.f \
	-o fir_bank_sim > build.log 2>&1 \
	&& ./obj_dir/fir_bank_sim > sim.log 2>&1 ; \
grep -q "Test completed successfully" sim.log \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL, see build.log and sim.log"; exit 1; }

/* tap_delay_line.sv */
`default_nettype none

module tap_delay_line (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  new_data_rdy,
	input  logic [fir_bank_pkg::sample_width-1:0] din,
	input  fir_bank_pkg::band_code_t              band_sel,
	output fir_bank_pkg::tap_window_t             window,
	output logic                                  window_strobe
);

	// hist[0] is the sample from one strobe back
	logic [fir_bank_pkg::hist_depth-1:0][fir_bank_pkg::sample_width-1:0] hist;

	// shared history, moves only when a new sample arrives
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hist <= '0;
		end
		else if (new_data_rdy)
		begin
			hist <= {hist[fir_bank_pkg::hist_depth-2:0], din};
		end
	end

	// current sample goes in front of the stored history
	always_comb
	begin
		window.taps = {hist, din};
		window.code = band_sel;
	end

	// filters sample the window on the same edge that shifts the history
	assign window_strobe = new_data_rdy;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter int period = 40,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
	end

	always #(period / 2) clk = ~clk;

	// start high so the drop is a real falling edge
	initial
	begin
		arst_n = 1'b1;
		#1 arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire
